//--- key_expand_pkg.sv
//////////////////////////////
// AES-128 key expansion definitions
// Round count and Rcon start values
// Key word, key and control types
// GF(2^8) doubling and halving
//////////////////////////////

package key_expand_pkg;

  //////////////////////////////
  // Constants
  //////////////////////////////

  // AES-128 has ten rounds after the initial key addition
  localparam int NumRounds = 10;

  // Rcon of round 1, used as start value in forward direction
  localparam logic [7:0] RconFwdInit = 8'h01;
  // Rcon of round 10, used as start value in inverse direction
  localparam logic [7:0] RconInvInit = 8'h36;

  // Reduction polynomial x^8 + x^4 + x^3 + x + 1 without the x^8 term
  localparam logic [7:0] GfPoly = 8'h1b;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Direction of the key schedule walk
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Round index, 0 to NumRounds
  typedef logic [3:0] round_t;

  // One key word, first FIPS byte in bits 31:24
  typedef logic [31:0] key_word_t;

  // Word 0 sits in the upper bits so a FIPS hex string maps straight on
  typedef key_word_t [0:3] key_t;

  // Control from the round controller to the datapath
  typedef struct packed {
    ciph_op_e   op;
    logic [7:0] rcon;
    logic       load;
  } key_ctrl_t;

  //////////////////////////////
  // GF(2^8) helpers
  //////////////////////////////

  // Multiply by x, reduce if bit 7 falls off
  function automatic logic [7:0] gf_mul2(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? GfPoly : 8'h00);
  endfunction

  // Divide by x, an odd byte had bit 7 set before the reduction
  function automatic logic [7:0] gf_div2(logic [7:0] b);
    return b[0] ? (((b ^ GfPoly) >> 1) | 8'h80) : (b >> 1);
  endfunction

endpackage

//--- aes_sbox_lut.sv
//////////////////////////////
// Forward AES S-Box
// 256-entry constant table, one byte lookup
//////////////////////////////

module aes_sbox_lut (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Table rows hold 8 entries, two rows per upper nibble
  localparam logic [7:0] SboxFwd [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Pure lookup, no clock
  assign data_o = SboxFwd[data_i];

endmodule

//--- key_round_ctrl.sv
//////////////////////////////
// Key expansion round controller
// Direction latch, round counter
// Rcon register, done flag
//////////////////////////////

module key_round_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  key_expand_pkg::ciph_op_e  op_i,
  input  logic                      step_i,
  output key_expand_pkg::key_ctrl_t ctrl_o,
  output logic                      advance_o,
  output key_expand_pkg::round_t    round_o,
  output logic                      done_o
);

  key_expand_pkg::ciph_op_e op_q;
  key_expand_pkg::round_t   round_q;
  logic [7:0]               rcon_q;
  logic [7:0]               rcon_next;

  // Last round reached, further steps are dropped
  assign done_o = (round_q == key_expand_pkg::round_t'(key_expand_pkg::NumRounds));

  // Clear has priority over a step in the same cycle
  assign advance_o = step_i & ~done_o & ~clear_i;

  //////////////////////////////
  // Rcon update
  //////////////////////////////

  // Forward doubles, inverse halves
  assign rcon_next = (op_q == key_expand_pkg::CIPH_FWD) ? key_expand_pkg::gf_mul2(rcon_q)
                                                       : key_expand_pkg::gf_div2(rcon_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q    <= key_expand_pkg::CIPH_FWD;
      round_q <= '0;
      rcon_q  <= '0;
    end else if (clear_i) begin
      // Restart at round 0 with the start Rcon of the new direction
      op_q    <= op_i;
      round_q <= '0;
      rcon_q  <= (op_i == key_expand_pkg::CIPH_FWD) ? key_expand_pkg::RconFwdInit
                                                    : key_expand_pkg::RconInvInit;
    end else if (advance_o) begin
      round_q <= round_q + 4'd1;
      rcon_q  <= rcon_next;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Load tracks the clear pulse of this cycle
  assign ctrl_o.op   = op_q;
  assign ctrl_o.rcon = rcon_q;
  assign ctrl_o.load = clear_i;

  assign round_o = round_q;

endmodule

//--- key_sub_word.sv
//////////////////////////////
// Irregular word of the key schedule
// Feedback select, RotWord, SubWord, Rcon
//////////////////////////////

module key_sub_word (
  input  key_expand_pkg::key_t      key_i,
  input  key_expand_pkg::key_ctrl_t ctrl_i,
  output key_expand_pkg::key_word_t irregular_o
);

  key_expand_pkg::key_word_t spec_in;
  key_expand_pkg::key_word_t rot_word_in;
  key_expand_pkg::key_word_t rot_word_out;
  key_expand_pkg::key_word_t sub_word_out;

  // Special input, word 3 of the previous round key
  assign spec_in = key_i[3] ^ key_i[2];

  // Feedback word select
  always_comb begin
    unique case (ctrl_i.op)
      key_expand_pkg::CIPH_FWD: rot_word_in = key_i[3];
      key_expand_pkg::CIPH_INV: rot_word_in = spec_in;
      default:                  rot_word_in = key_i[3];
    endcase
  end

  // RotWord, first byte moves to the end
  assign rot_word_out = {rot_word_in[23:0], rot_word_in[31:24]};

  //////////////////////////////
  // SubWord
  //////////////////////////////

  // One table per byte lane
  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox_lut u_aes_sbox_lut (
      .data_i ( rot_word_out[8*i +: 8] ),
      .data_o ( sub_word_out[8*i +: 8] )
    );
  end

  // Rcon goes into the first byte only
  assign irregular_o = sub_word_out ^ {ctrl_i.rcon, 24'h000000};

endmodule

//--- key_word_mix.sv
//////////////////////////////
// Regular part of the key schedule
// Forward and inverse XOR chains
// Round key state register
//////////////////////////////

module key_word_mix (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  key_expand_pkg::key_t      key_i,
  input  key_expand_pkg::key_ctrl_t ctrl_i,
  input  logic                      advance_i,
  input  key_expand_pkg::key_word_t irregular_i,
  output key_expand_pkg::key_t      key_o
);

  key_expand_pkg::key_t key_q;
  key_expand_pkg::key_t mixed;

  //////////////////////////////
  // XOR chains
  //////////////////////////////

  always_comb begin
    // Word 0 takes the irregular word in both directions
    mixed    = key_q;
    mixed[0] = irregular_i ^ key_q[0];
    unique case (ctrl_i.op)
      key_expand_pkg::CIPH_FWD: begin
        // Ripple through the new words
        for (int i = 1; i < 4; i++) begin
          mixed[i] = mixed[i-1] ^ key_q[i];
        end
      end
      key_expand_pkg::CIPH_INV: begin
        // Adjacent old words undo the forward ripple
        for (int i = 1; i < 4; i++) begin
          mixed[i] = key_q[i-1] ^ key_q[i];
        end
      end
      default: begin
        mixed = key_q;
      end
    endcase
  end

  //////////////////////////////
  // State register
  //////////////////////////////

  // Load wins, a step never coincides with it anyway
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (ctrl_i.load) begin
      key_q <= key_i;
    end else if (advance_i) begin
      key_q <= mixed;
    end
  end

  assign key_o = key_q;

endmodule

//--- key_expand_top.sv
//////////////////////////////
// AES-128 round key generator top
// Controller, irregular word, XOR chains
//////////////////////////////

module key_expand_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  key_expand_pkg::ciph_op_e op_i,
  input  logic                     step_i,
  input  key_expand_pkg::key_t     key_i,
  output key_expand_pkg::key_t     key_o,
  output key_expand_pkg::round_t   round_o,
  output logic                     done_o
);

  key_expand_pkg::key_ctrl_t ctrl;
  logic                      advance;
  key_expand_pkg::key_t      key_state;
  key_expand_pkg::key_word_t irregular;

  // Input side, strobes and round bookkeeping
  key_round_ctrl u_key_round_ctrl (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .clear_i   ( clear_i ),
    .op_i      ( op_i    ),
    .step_i    ( step_i  ),
    .ctrl_o    ( ctrl    ),
    .advance_o ( advance ),
    .round_o   ( round_o ),
    .done_o    ( done_o  )
  );

  // Feedback from the current state
  key_sub_word u_key_sub_word (
    .key_i       ( key_state ),
    .ctrl_i      ( ctrl      ),
    .irregular_o ( irregular )
  );

  // Output side holds the round key
  key_word_mix u_key_word_mix (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .key_i       ( key_i     ),
    .ctrl_i      ( ctrl      ),
    .advance_i   ( advance   ),
    .irregular_i ( irregular ),
    .key_o       ( key_state )
  );

  assign key_o = key_state;

endmodule

//--- key_expand_checker.sv
//////////////////////////////
// Concurrent assertions on the round controller
// Attached to key_round_ctrl with bind
//////////////////////////////

module key_expand_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   clear_i,
  input logic                   advance_i,
  input key_expand_pkg::round_t round_i,
  input logic                   done_i
);

  // Number of failed assertions, read back by the testbench
  int unsigned assert_fails = 0;

  // Done appears only with the step from the second to last round
  done_at_last_round: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(done_i) |-> ($past(advance_i) &&
                       ($past(round_i) == key_expand_pkg::round_t'(key_expand_pkg::NumRounds - 1))))
    else begin
      $error("done flag rose without the step into the last round, round %0d", round_i);
      assert_fails++;
    end

  // A finished expansion holds its round until the next clear
  no_advance_when_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done_i && !clear_i) |=> (done_i && $stable(round_i)))
    else begin
      $error("round counter moved to %0d after the last round", round_i);
      assert_fails++;
    end

  // Clear restarts the count
  clear_resets_round: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (round_i == '0))
    else begin
      $error("round counter is %0d one cycle after clear", round_i);
      assert_fails++;
    end

endmodule

bind key_round_ctrl key_expand_checker u_key_expand_checker (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .clear_i   ( clear_i   ),
  .advance_i ( advance_o ),
  .round_i   ( round_o   ),
  .done_i    ( done_o    )
);

//--- tb_key_expand.sv
//////////////////////////////
// Testbench for the AES-128 round key generator
// Stim file records, xorshift round trips
// Clear over step, reporting, watchdog
//////////////////////////////

module tb_key_expand;

  localparam int ClkHalf         = 20;
  localparam int ResetCycles     = 8;
  localparam int CyclesPerRecord = 16;
  localparam int WatchdogSlack   = 200;
  localparam int NumRoundTrips   = 8;

  // FIPS-197 appendix A.1 cipher key and its round keys 1 and 3
  localparam logic [127:0] FipsKey    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] FipsRound1 = 128'ha0fafe1788542cb123a339392a6c7605;
  localparam logic [127:0] FipsRound3 = 128'h3d80477d4716fe3e1e237e446d7a883b;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  key_expand_pkg::ciph_op_e op_i;
  logic                     step_i;
  key_expand_pkg::key_t     key_i;
  key_expand_pkg::key_t     key_o;
  key_expand_pkg::round_t   round_o;
  logic                     done_o;

  // Records from the stim file
  int unsigned  rec_dir [$];
  logic [127:0] rec_key [$];
  int unsigned  rec_steps [$];
  logic [127:0] rec_exp [$];
  bit           records_loaded;

  int          num_tests;
  int          num_failed;
  int          num_errors;
  int          test_errors;
  logic [31:0] rng_state;

  key_expand_top dut (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .clear_i ( clear_i ),
    .op_i    ( op_i    ),
    .step_i  ( step_i  ),
    .key_i   ( key_i   ),
    .key_o   ( key_o   ),
    .round_o ( round_o ),
    .done_o  ( done_o  )
  );

  always #ClkHalf clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Four draws, one per key word
  task automatic next_random_key(output key_expand_pkg::key_t k);
    for (int i = 0; i < 4; i++) begin
      rng_state = xorshift32(rng_state);
      k[i] = rng_state;
    end
  endtask

  task automatic read_stim_file();
    int           fd;
    int           n;
    string        line;
    int unsigned  dir;
    int unsigned  steps;
    logic [127:0] start_key;
    logic [127:0] exp_key;
    fd = $fopen("key_expand_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open key_expand_stim.txt");
      num_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip blank and comment lines
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %h %d %h", dir, start_key, steps, exp_key);
      if (n == 4) begin
        rec_dir.push_back(dir);
        rec_key.push_back(start_key);
        rec_steps.push_back(steps);
        rec_exp.push_back(exp_key);
      end
    end
    $fclose(fd);
    if (rec_key.size() == 0) begin
      $display("No records found in key_expand_stim.txt");
      num_errors++;
    end
  endtask

  // Called at a falling edge, returns at the next one with clear low
  task automatic clear_key(key_expand_pkg::ciph_op_e op, key_expand_pkg::key_t k);
    clear_i = 1'b1;
    op_i    = op;
    key_i   = k;
    @(negedge clk_i);
    clear_i = 1'b0;
  endtask

  // Back to back step pulses, one per cycle
  task automatic step_pulses(int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      step_i = 1'b1;
      @(negedge clk_i);
    end
    step_i = 1'b0;
  endtask

  task automatic step_until_done(int limit);
    int cycles;
    cycles = 0;
    step_i = 1'b1;
    while (!done_o && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
    end
    step_i = 1'b0;
    assert (done_o) else begin
      $display("done_o stayed low after %0d cycles of stepping", limit);
      test_errors++;
    end
  endtask

  task automatic check_state(key_expand_pkg::key_t exp_key, key_expand_pkg::round_t exp_round,
                             logic exp_done);
    assert (key_o === exp_key) else begin
      $display("ERR t=%0t key_o expected %h got %h", $time, exp_key, key_o);
      test_errors++;
    end
    assert (round_o === exp_round) else begin
      $display("ERR t=%0t round_o expected %0d got %0d", $time, exp_round, round_o);
      test_errors++;
    end
    assert (done_o === exp_done) else begin
      $display("ERR t=%0t done_o expected %b got %b", $time, exp_done, done_o);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    num_tests++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", num_tests, name);
    end else begin
      $display("test %0d %s: %0d error(s)", num_tests, name, test_errors);
      num_failed++;
    end
    num_errors += test_errors;
    test_errors = 0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    key_expand_pkg::key_t     start_key;
    key_expand_pkg::key_t     fwd_key;
    key_expand_pkg::round_t   exp_round;
    key_expand_pkg::ciph_op_e dir;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    op_i        = key_expand_pkg::CIPH_FWD;
    step_i      = 1'b0;
    key_i       = '0;
    rng_state   = 32'h919df829;
    num_tests   = 0;
    num_failed  = 0;
    num_errors  = 0;
    test_errors = 0;
    read_stim_file();
    records_loaded = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_state('0, '0, 1'b0);
    finish_test("reset state");

    // Known vectors, step counts past the last round must be ignored
    for (int r = 0; r < rec_key.size(); r++) begin
      dir = (rec_dir[r] != 0) ? key_expand_pkg::CIPH_INV : key_expand_pkg::CIPH_FWD;
      clear_key(dir, rec_key[r]);
      check_state(rec_key[r], '0, 1'b0);
      step_pulses(rec_steps[r]);
      if (rec_steps[r] > key_expand_pkg::NumRounds) begin
        exp_round = key_expand_pkg::round_t'(key_expand_pkg::NumRounds);
      end else begin
        exp_round = key_expand_pkg::round_t'(rec_steps[r]);
      end
      check_state(rec_exp[r], exp_round, exp_round == key_expand_pkg::NumRounds);
      finish_test($sformatf("stim record %0d", r));
    end

    // Forward walk then inverse walk must return the start key
    for (int t = 0; t < NumRoundTrips; t++) begin
      next_random_key(start_key);
      clear_key(key_expand_pkg::CIPH_FWD, start_key);
      step_until_done(2 * key_expand_pkg::NumRounds);
      fwd_key = key_o;
      clear_key(key_expand_pkg::CIPH_INV, fwd_key);
      step_until_done(2 * key_expand_pkg::NumRounds);
      check_state(start_key, key_expand_pkg::round_t'(key_expand_pkg::NumRounds), 1'b1);
      finish_test($sformatf("round trip %0d", t));
    end

    // Clear and step together partway through an expansion
    clear_key(key_expand_pkg::CIPH_FWD, FipsKey);
    step_pulses(3);
    check_state(FipsRound3, 4'd3, 1'b0);
    step_i = 1'b1;
    clear_key(key_expand_pkg::CIPH_FWD, FipsKey);
    step_i = 1'b0;
    check_state(FipsKey, '0, 1'b0);
    step_pulses(1);
    check_state(FipsRound1, 4'd1, 1'b0);
    finish_test("clear over step");

    // Assertion failures from the bound checker count as errors
    num_errors += dut.u_key_round_ctrl.u_key_expand_checker.assert_fails;
    $display("tests %0d, failed %0d, errors %0d", num_tests, num_failed, num_errors);
    if (num_failed == 0 && num_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    wait (records_loaded);
    repeat (rec_key.size() * CyclesPerRecord + WatchdogSlack) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

//--- key_expand_stim.txt
# dir (0 forward, 1 inverse)  start key  step count  expected key
# Keys are 32 hex digits with FIPS-197 word 0 first, step count is decimal
0 2b7e151628aed2a6abf7158809cf4f3c 0 2b7e151628aed2a6abf7158809cf4f3c
0 2b7e151628aed2a6abf7158809cf4f3c 1 a0fafe1788542cb123a339392a6c7605
0 2b7e151628aed2a6abf7158809cf4f3c 2 f2c295f27a96b9435935807a7359f67f
0 2b7e151628aed2a6abf7158809cf4f3c 3 3d80477d4716fe3e1e237e446d7a883b
0 2b7e151628aed2a6abf7158809cf4f3c 4 ef44a541a8525b7fb671253bdb0bad00
0 2b7e151628aed2a6abf7158809cf4f3c 10 d014f9a8c9ee2589e13f0cc8b6630ca6
0 2b7e151628aed2a6abf7158809cf4f3c 13 d014f9a8c9ee2589e13f0cc8b6630ca6
1 d014f9a8c9ee2589e13f0cc8b6630ca6 1 ac7766f319fadc2128d12941575c006e
1 d014f9a8c9ee2589e13f0cc8b6630ca6 5 d4d1c6f87c839d87caf2b8bc11f915bc
1 d014f9a8c9ee2589e13f0cc8b6630ca6 10 2b7e151628aed2a6abf7158809cf4f3c
1 d014f9a8c9ee2589e13f0cc8b6630ca6 14 2b7e151628aed2a6abf7158809cf4f3c
0 000102030405060708090a0b0c0d0e0f 1 d6aa74fdd2af72fadaa678f1d6ab76fe
0 000102030405060708090a0b0c0d0e0f 10 13111d7fe3944a17f307a78b4d2b30c5
1 13111d7fe3944a17f307a78b4d2b30c5 10 000102030405060708090a0b0c0d0e0f
0 00000000000000000000000000000000 1 62636363626363636263636362636363

//--- sources.f
key_expand_pkg.sv
aes_sbox_lut.sv
key_round_ctrl.sv
key_sub_word.sv
key_word_mix.sv
key_expand_top.sv
key_expand_checker.sv
tb_key_expand.sv
